// File: source/accel_defs.svh
// ==============================
// Accelerator shared constants
// Buffer depth, array size, host address map
// ==============================
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// Operand buffers
`define ACCEL_K_MAX 16
`define ACCEL_K_W   4

// Array geometry
`define ACCEL_DIM   2
`define ACCEL_ACC_W 32

// Host word address, region code in bits 7:6
`define ACCEL_ADR_W   8
`define ACCEL_RGN_CSR 2'd0
`define ACCEL_RGN_ACT 2'd1
`define ACCEL_RGN_WGT 2'd2
`define ACCEL_RGN_RES 2'd3

// Register offsets in bits 1:0
`define ACCEL_CSR_CTRL   2'd0
`define ACCEL_CSR_STATUS 2'd1
`define ACCEL_CSR_KLEN   2'd2
`define ACCEL_CSR_CYCLES 2'd3

`endif

// File: source/accel_pkg.sv
// ==============================
// Accelerator types
// Bus request, host word views, array control
// ==============================
`include "accel_defs.svh"

package accel_pkg;

    // Two signed int8 lanes, one buffer entry or one array vector
    typedef struct packed {
        logic signed [7:0] lane1;
        logic signed [7:0] lane0;
    } operand_t;

    // One host data word, seen as a register value or as a buffer entry
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] pad;
            operand_t    ops;
        } lane;
    } host_word_u;

    // Registered Wishbone request
    typedef struct packed {
        logic                    we;
        logic [`ACCEL_ADR_W-1:0] adr;
        host_word_u              dat;
    } bus_req_t;

    // Scheduler to array
    typedef struct packed {
        logic clear;
        logic enable;
    } array_ctrl_t;

endpackage

// File: source/operand_buffer.sv
// ==============================
// Operand buffer
// 16 two-lane int8 entries, registered read
// ==============================
`timescale 1ns/100ps
`include "accel_defs.svh"

module operand_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_we,
    input  logic [`ACCEL_K_W-1:0] i_wr_idx,
    input  accel_pkg::operand_t   i_wr_data,
    input  logic [`ACCEL_K_W-1:0] i_rd_idx,
    output accel_pkg::operand_t   o_rd_data
);
    import accel_pkg::*;

    operand_t mem [`ACCEL_K_MAX];

    // Host write port
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wr_idx] <= i_wr_data;
        end
    end

    // Scheduler read port, data one cycle after the index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rd_data <= '0;
        end else begin
            o_rd_data <= mem[i_rd_idx];
        end
    end

endmodule

// File: source/systolic_array.sv
// ==============================
// Output-stationary systolic array
// 2x2 int8 MAC cells, 32-bit accumulators
// ==============================
`timescale 1ns/100ps
`include "accel_defs.svh"

module systolic_array (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  accel_pkg::array_ctrl_t                            i_ctrl,
    input  accel_pkg::operand_t                               i_act,
    input  accel_pkg::operand_t                               i_wgt,
    output logic [`ACCEL_DIM*`ACCEL_DIM*`ACCEL_ACC_W-1:0]     o_result
);
    import accel_pkg::*;

    localparam int DIM  = `ACCEL_DIM;
    localparam int ACC  = `ACCEL_ACC_W;
    localparam int EN_W = 2 * DIM - 2;

    // Lane r of the skewed edge vectors feeds row r or column r
    operand_t              row_in;
    operand_t              col_in;
    logic signed [7:0]     act1_q;
    logic signed [7:0]     wgt1_q;
    logic [EN_W-1:0]       en_sr;
    logic [EN_W:0]         en_tap;
    logic signed [7:0]     a_pipe [DIM][DIM-1];
    logic signed [7:0]     w_pipe [DIM-1][DIM];
    logic signed [ACC-1:0] acc    [DIM][DIM];

    // ==============================
    // Input skew and enable delay line
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act1_q <= '0;
            wgt1_q <= '0;
            en_sr  <= '0;
        end else if (i_ctrl.clear) begin
            act1_q <= '0;
            wgt1_q <= '0;
            en_sr  <= '0;
        end else begin
            act1_q <= i_act.lane1;
            wgt1_q <= i_wgt.lane1;
            en_sr  <= {en_sr[EN_W-2:0], i_ctrl.enable};
        end
    end

    assign row_in.lane0 = i_act.lane0;
    assign row_in.lane1 = act1_q;
    assign col_in.lane0 = i_wgt.lane0;
    assign col_in.lane1 = wgt1_q;
    // Cell (r,c) sees the enable delayed by r+c
    assign en_tap = {en_sr, i_ctrl.enable};

    // ==============================
    // MAC cells
    // ==============================
    for (genvar r = 0; r < DIM; r++) begin : g_row
        for (genvar c = 0; c < DIM; c++) begin : g_col
            logic signed [7:0] a_in;
            logic signed [7:0] w_in;

            if (c == 0) begin : g_a_edge
                assign a_in = $signed(row_in[r*8 +: 8]);
            end else begin : g_a_pass
                assign a_in = a_pipe[r][c-1];
            end

            if (r == 0) begin : g_w_edge
                assign w_in = $signed(col_in[c*8 +: 8]);
            end else begin : g_w_pass
                assign w_in = w_pipe[r-1][c];
            end

            // Activation moves right
            if (c < DIM - 1) begin : g_a_reg
                always_ff @(posedge clk or negedge rst_n) begin
                    if (!rst_n) begin
                        a_pipe[r][c] <= '0;
                    end else if (i_ctrl.clear) begin
                        a_pipe[r][c] <= '0;
                    end else begin
                        a_pipe[r][c] <= a_in;
                    end
                end
            end

            // Weight moves down
            if (r < DIM - 1) begin : g_w_reg
                always_ff @(posedge clk or negedge rst_n) begin
                    if (!rst_n) begin
                        w_pipe[r][c] <= '0;
                    end else if (i_ctrl.clear) begin
                        w_pipe[r][c] <= '0;
                    end else begin
                        w_pipe[r][c] <= w_in;
                    end
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    acc[r][c] <= '0;
                end else if (i_ctrl.clear) begin
                    acc[r][c] <= '0;
                end else if (en_tap[r+c]) begin
                    acc[r][c] <= acc[r][c] + ACC'(a_in) * ACC'(w_in);
                end
            end

            assign o_result[(r*DIM+c)*ACC +: ACC] = acc[r][c];
        end
    end

endmodule

// File: source/accel_ctrl.sv
// ==============================
// Accelerator control
// Wishbone slave, registers, run scheduler
// ==============================
`timescale 1ns/100ps
`include "accel_defs.svh"

module accel_ctrl (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          i_wb_cyc,
    input  logic                                          i_wb_stb,
    input  logic                                          i_wb_we,
    input  logic [`ACCEL_ADR_W-1:0]                       i_wb_adr,
    input  logic [31:0]                                   i_wb_dat,
    output logic [31:0]                                   o_wb_dat,
    output logic                                          o_wb_ack,
    output logic                                          o_act_we,
    output logic                                          o_wgt_we,
    output logic [`ACCEL_K_W-1:0]                         o_wr_idx,
    output accel_pkg::operand_t                           o_wr_data,
    output logic [`ACCEL_K_W-1:0]                         o_rd_idx,
    output accel_pkg::array_ctrl_t                        o_array,
    input  logic [`ACCEL_DIM*`ACCEL_DIM*`ACCEL_ACC_W-1:0] i_result,
    output logic                                          o_busy,
    output logic                                          o_done
);
    import accel_pkg::*;

    // Last drain cycle: last enable, two skew stages, final accumulate
    localparam logic [`ACCEL_K_W-1:0] DRAIN_LAST = 4'd3;

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_DRAIN, ST_FINISH} state_t;

    bus_req_t              req_q;
    logic                  req_seen;
    logic [1:0]            rgn;
    logic [1:0]            reg_off;
    logic                  wr_stb;
    logic                  start;
    state_t                state_q;
    logic [`ACCEL_K_W-1:0] cnt_q;
    logic [`ACCEL_K_W-1:0] klen_q;
    logic [`ACCEL_K_W-1:0] k_last;
    logic [`ACCEL_K_W:0]   k_eff;
    logic                  en_q;
    logic                  done_q;
    logic [31:0]           run_cnt_q;
    logic [31:0]           cycles_q;

    // ==============================
    // Wishbone slave
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_seen <= 1'b0;
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= 1'b0;
            if (!(i_wb_cyc && i_wb_stb)) begin
                req_seen <= 1'b0;
            end else if (!req_seen) begin
                req_seen <= 1'b1;
                o_wb_ack <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_wb_cyc && i_wb_stb && !req_seen) begin
            req_q.we      <= i_wb_we;
            req_q.adr     <= i_wb_adr;
            req_q.dat.raw <= i_wb_dat;
        end
    end

    // Request decode, acted on in the ack cycle
    assign rgn     = req_q.adr[7:6];
    assign reg_off = req_q.adr[1:0];
    assign wr_stb  = o_wb_ack && req_q.we;
    assign start   = wr_stb && (rgn == `ACCEL_RGN_CSR) && (reg_off == `ACCEL_CSR_CTRL)
                     && req_q.dat.raw[0] && !o_busy;

    // Buffers are locked while a run reads them
    assign o_act_we  = wr_stb && (rgn == `ACCEL_RGN_ACT) && !o_busy;
    assign o_wgt_we  = wr_stb && (rgn == `ACCEL_RGN_WGT) && !o_busy;
    assign o_wr_idx  = req_q.adr[`ACCEL_K_W-1:0];
    assign o_wr_data = req_q.dat.lane.ops;

    // KLEN of 0 stands for 16
    assign k_eff  = {(klen_q == '0), klen_q};
    assign k_last = klen_q - 4'd1;

    always_comb begin
        o_wb_dat = '0;
        case (rgn)
            `ACCEL_RGN_CSR: begin
                case (reg_off)
                    `ACCEL_CSR_STATUS: o_wb_dat = {30'd0, done_q, o_busy};
                    `ACCEL_CSR_KLEN:   o_wb_dat = {27'd0, k_eff};
                    `ACCEL_CSR_CYCLES: o_wb_dat = cycles_q;
                    default:           o_wb_dat = '0;
                endcase
            end
            `ACCEL_RGN_RES: o_wb_dat = i_result[reg_off*`ACCEL_ACC_W +: `ACCEL_ACC_W];
            default:        o_wb_dat = '0;
        endcase
    end

    // ==============================
    // Run scheduler
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            klen_q    <= '0;
            en_q      <= 1'b0;
            done_q    <= 1'b0;
            run_cnt_q <= '0;
            cycles_q  <= '0;
        end else begin
            en_q <= (state_q == ST_READ);
            if (wr_stb && (rgn == `ACCEL_RGN_CSR) && (reg_off == `ACCEL_CSR_KLEN) && !o_busy) begin
                klen_q <= req_q.dat.raw[`ACCEL_K_W-1:0];
            end
            case (state_q)
                ST_READ: begin
                    run_cnt_q <= run_cnt_q + 32'd1;
                    cnt_q     <= cnt_q + 4'd1;
                    if (cnt_q == k_last) begin
                        state_q <= ST_DRAIN;
                        cnt_q   <= '0;
                    end
                end
                ST_DRAIN: begin
                    run_cnt_q <= run_cnt_q + 32'd1;
                    cnt_q     <= cnt_q + 4'd1;
                    if (cnt_q == DRAIN_LAST) begin
                        state_q <= ST_FINISH;
                    end
                end
                default: begin
                    if (state_q == ST_FINISH) begin
                        done_q   <= 1'b1;
                        cycles_q <= run_cnt_q;
                    end
                    state_q <= ST_IDLE;
                    if (start) begin
                        state_q   <= ST_READ;
                        cnt_q     <= '0;
                        run_cnt_q <= '0;
                        done_q    <= 1'b0;
                    end
                end
            endcase
        end
    end

    assign o_busy         = (state_q == ST_READ) || (state_q == ST_DRAIN);
    assign o_done         = (state_q == ST_FINISH);
    assign o_rd_idx       = cnt_q;
    // Clear on the first read cycle, enable one cycle behind each read
    assign o_array.clear  = (state_q == ST_READ) && (cnt_q == '0);
    assign o_array.enable = en_q;

endmodule

// File: source/accel_top.sv
// ==============================
// Dense matrix accelerator top
// Wishbone host port, buffers, 2x2 array
// ==============================
`timescale 1ns/100ps
`include "accel_defs.svh"

module accel_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    input  logic                    i_wb_we,
    input  logic [`ACCEL_ADR_W-1:0] i_wb_adr,
    input  logic [31:0]             i_wb_dat,
    output logic [31:0]             o_wb_dat,
    output logic                    o_wb_ack,
    output logic                    o_busy,
    output logic                    o_done
);

    logic                                          act_we;
    logic                                          wgt_we;
    logic [`ACCEL_K_W-1:0]                         wr_idx;
    logic [`ACCEL_K_W-1:0]                         rd_idx;
    accel_pkg::operand_t                           wr_data;
    accel_pkg::operand_t                           act_data;
    accel_pkg::operand_t                           wgt_data;
    accel_pkg::array_ctrl_t                        array_ctrl;
    logic [`ACCEL_DIM*`ACCEL_DIM*`ACCEL_ACC_W-1:0] result;

    accel_ctrl ctrl0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .o_act_we  (act_we),
        .o_wgt_we  (wgt_we),
        .o_wr_idx  (wr_idx),
        .o_wr_data (wr_data),
        .o_rd_idx  (rd_idx),
        .o_array   (array_ctrl),
        .i_result  (result),
        .o_busy    (o_busy),
        .o_done    (o_done)
    );

    // Activations feed the rows, weights the columns
    operand_buffer act_buf0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_we      (act_we),
        .i_wr_idx  (wr_idx),
        .i_wr_data (wr_data),
        .i_rd_idx  (rd_idx),
        .o_rd_data (act_data)
    );

    operand_buffer wgt_buf0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_we      (wgt_we),
        .i_wr_idx  (wr_idx),
        .i_wr_data (wr_data),
        .i_rd_idx  (rd_idx),
        .o_rd_data (wgt_data)
    );

    systolic_array array0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_ctrl   (array_ctrl),
        .i_act    (act_data),
        .i_wgt    (wgt_data),
        .o_result (result)
    );

endmodule

// File: test/accel_sva.sv
// ==============================
// Host bus and run timing checks
// Bound into the control module
// ==============================
`timescale 1ns/100ps

module accel_sva (
    input logic       clk,
    input logic       rst_n,
    input logic       i_wb_cyc,
    input logic       i_wb_stb,
    input logic       i_wb_ack,
    input logic       i_busy,
    input logic       i_done,
    input logic [3:0] i_klen
);

    int unsigned fail_cnt = 0;
    logic        req;
    logic [5:0]  busy_len;
    logic [5:0]  run_len;

    assign req = i_wb_cyc && i_wb_stb;
    // K reads plus read latency and skew drain
    assign run_len = (i_klen == 4'd0) ? 6'd20 : {2'b00, i_klen} + 6'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_len <= '0;
        end else if (i_busy) begin
            busy_len <= busy_len + 6'd1;
        end else begin
            busy_len <= '0;
        end
    end

    // ==============================
    // Wishbone handshake
    // ==============================
    ack_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !i_wb_ack)
        else begin
            $error("ack high in the first cycle after reset");
            fail_cnt++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        i_wb_ack |=> !i_wb_ack)
        else begin
            $error("ack held for more than one cycle");
            fail_cnt++;
        end

    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |=> i_wb_ack)
        else begin
            $error("no ack one cycle after a new request");
            fail_cnt++;
        end

    // ==============================
    // Run timing
    // ==============================
    busy_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(i_busy) |-> (busy_len == run_len))
        else begin
            $error("busy length differs from K+4 cycles");
            fail_cnt++;
        end

    done_at_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(i_busy) |-> i_done)
        else begin
            $error("done not raised as busy falls");
            fail_cnt++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        i_done |=> !i_done)
        else begin
            $error("done held for more than one cycle");
            fail_cnt++;
        end

endmodule

// File: test/accel_tb.sv
// ==============================
// Accelerator testbench
// Wishbone host tasks, random dense products
// ==============================
`timescale 1ns/100ps
`include "accel_defs.svh"

module accel_tb;

    // About 200 bus accesses of 3 cycles and four runs with 3x margin
    localparam int TEST_CYCLES = 16 + 200 * 3 + 4 * 20;
    localparam int WATCHDOG_NS = TEST_CYCLES * 10 * 3;

    logic              clk;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [7:0]        wb_adr;
    logic [31:0]       wb_dat_w;
    logic [31:0]       wb_dat_r;
    logic              wb_ack;
    logic              busy;
    logic              done;
    logic [31:0]       lcg_state;
    logic signed [7:0] act_m [16][2];
    logic signed [7:0] wgt_m [16][2];
    int                errors;
    int                checks;
    int                runs;
    int                done_cnt;

    accel_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack),
        .o_busy   (busy),
        .o_done   (done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Done pulses seen on the top-level output
    always @(negedge clk) begin
        if (done) begin
            done_cnt++;
        end
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Built from upper LCG bits since the low bits repeat quickly
    task automatic rand_word(output logic [31:0] w);
        lcg_state = lcg_step(lcg_state);
        w[31:16] = lcg_state[31:16];
        lcg_state = lcg_step(lcg_state);
        w[15:0] = lcg_state[31:16];
    endtask

    function automatic logic [7:0] csr_adr(input logic [1:0] off);
        return {`ACCEL_RGN_CSR, 4'd0, off};
    endfunction

    function automatic logic [7:0] buf_adr(input logic [1:0] rgn, input logic [3:0] idx);
        return {rgn, 2'b00, idx};
    endfunction

    function automatic logic [7:0] res_adr(input logic [1:0] idx);
        return {`ACCEL_RGN_RES, 4'd0, idx};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s expected %0d actual %0d", name, $signed(expected),
                     $signed(actual));
            errors++;
        end
    endtask

    task automatic bus_access(input logic we, input logic [7:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        // Ack and read data sampled mid-cycle
        do begin
            @(negedge clk);
        end while (!wb_ack);
        rdat = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] rd_ignored;
        bus_access(1'b1, adr, dat, rd_ignored);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        bus_access(1'b0, adr, 32'd0, dat);
    endtask

    // Busy rises on the top-level output once the start is taken
    task automatic start_run(input string name);
        wb_write(csr_adr(`ACCEL_CSR_CTRL), 32'd1);
        @(negedge clk);
        check_value({name, "_busy"}, 32'd1, {31'd0, busy});
        runs++;
    endtask

    // Random pad bits go along and only the two low lanes count
    task automatic load_vectors(input int n);
        logic [31:0] w;
        for (int k = 0; k < n; k++) begin
            rand_word(w);
            act_m[k][0] = w[7:0];
            act_m[k][1] = w[15:8];
            wb_write(buf_adr(`ACCEL_RGN_ACT, k[3:0]), w);
            rand_word(w);
            wgt_m[k][0] = w[7:0];
            wgt_m[k][1] = w[15:8];
            wb_write(buf_adr(`ACCEL_RGN_WGT, k[3:0]), w);
        end
    endtask

    // C[i][j] = sum over k of A[k][i] * B[k][j]
    function automatic logic [31:0] model_sum(input int k_len, input int row, input int col);
        int sum;
        sum = 0;
        for (int k = 0; k < k_len; k++) begin
            sum += int'(act_m[k][row]) * int'(wgt_m[k][col]);
        end
        return sum;
    endfunction

    task automatic wait_done();
        logic [31:0] st;
        do begin
            wb_read(csr_adr(`ACCEL_CSR_STATUS), st);
        end while (!st[1]);
    endtask

    task automatic check_run(input string name, input int k_len);
        logic [31:0] rd;
        for (int i = 0; i < 4; i++) begin
            wb_read(res_adr(i[1:0]), rd);
            check_value($sformatf("%s_c%0d%0d", name, i / 2, i % 2),
                        model_sum(k_len, i / 2, i % 2), rd);
        end
        wb_read(csr_adr(`ACCEL_CSR_CYCLES), rd);
        check_value({name, "_cycles"}, k_len + 4, rd);
        check_value({name, "_done_pulses"}, runs, done_cnt);
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        logic [31:0] rd;
        errors    = 0;
        checks    = 0;
        runs      = 0;
        done_cnt  = 0;
        lcg_state = 32'd85;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Register readback
        wb_read(csr_adr(`ACCEL_CSR_STATUS), rd);
        check_value("status_reset", 32'd0, rd);
        wb_read(csr_adr(`ACCEL_CSR_KLEN), rd);
        check_value("klen_reset", 32'd16, rd);
        wb_write(csr_adr(`ACCEL_CSR_KLEN), 32'd5);
        wb_read(csr_adr(`ACCEL_CSR_KLEN), rd);
        check_value("klen_readback", 32'd5, rd);

        // Dense product with K=5, then run cycles
        load_vectors(5);
        start_run("dense_k5");
        wait_done();
        wb_read(csr_adr(`ACCEL_CSR_STATUS), rd);
        check_value("status_done", 32'd2, rd);
        check_run("dense_k5", 5);

        // Buffer writes to the last entry and a second start land inside a K=8 run
        load_vectors(8);
        wb_write(csr_adr(`ACCEL_CSR_KLEN), 32'd8);
        start_run("busy_k8");
        wb_write(buf_adr(`ACCEL_RGN_ACT, 4'd7), 32'h0000_7f7f);
        wb_write(buf_adr(`ACCEL_RGN_WGT, 4'd7), 32'h0000_8080);
        wb_write(csr_adr(`ACCEL_CSR_CTRL), 32'd1);
        wait_done();
        check_run("busy_k8", 8);

        // KLEN 0 runs all 16 entries
        load_vectors(16);
        wb_write(csr_adr(`ACCEL_CSR_KLEN), 32'd0);
        wb_read(csr_adr(`ACCEL_CSR_KLEN), rd);
        check_value("klen_zero", 32'd16, rd);
        start_run("full_k16");
        wait_done();
        check_run("full_k16", 16);

        // Fresh sums after the accumulators clear
        load_vectors(5);
        wb_write(csr_adr(`ACCEL_CSR_KLEN), 32'd5);
        start_run("rerun_k5");
        wait_done();
        check_run("rerun_k5", 5);

        repeat (4) @(posedge clk);
        $display("Checks %0d, value errors %0d, assertion errors %0d",
                 checks, errors, dut0.ctrl0.sva0.fail_cnt);
        if (errors == 0 && dut0.ctrl0.sva0.fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, a bus access or run never completed", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

// Protocol and timing checks inside the control module
bind accel_ctrl accel_sva sva0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_ack (o_wb_ack),
    .i_busy   (o_busy),
    .i_done   (o_done),
    .i_klen   (klen_q)
);

// File: sim.f
+incdir+source
source/accel_pkg.sv
source/operand_buffer.sv
source/systolic_array.sv
source/accel_ctrl.sv
source/accel_top.sv
test/accel_sva.sv
test/accel_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module accel_tb -f sim.f -o accel_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/accel_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
